// ==== source/timer_params.svh ====
`ifndef TIMER_PARAMS_SVH
`define TIMER_PARAMS_SVH

// Bus widths
`define RAM_ADDR_W 12
`define IO_ADDR_W 6

// Data-space register addresses
`define TCCRA_ADDR 12'h0B0
`define TCCRB_ADDR 12'h0B1
`define TCNT_ADDR 12'h0B2
`define OCRA_ADDR 12'h0B3
`define OCRB_ADDR 12'h0B4
`define TIMSK_ADDR 12'h070

// I/O-space flag register
`define TIFR_ADDR 6'h17

// Interrupt vector numbers seen on the acknowledge bus
`define VEC_CMPA 6'd7
`define VEC_CMPB 6'd8
`define VEC_OVF 6'd9

`endif

// ==== source/timerPkg.sv ====
package timerPkg;

	typedef logic [7:0] byteT;

	// Encoding is {WGM2, WGM1, WGM0}
	typedef enum logic [2:0] {
		normal   = 3'b000,
		pcPwmFf  = 3'b001,
		ctc      = 3'b010,
		fastFf   = 3'b011,
		pcPwmOcr = 3'b101,
		fastOcr  = 3'b111
	} wgmT;

	typedef enum logic [1:0] {
		off    = 2'b00,
		toggle = 2'b01,
		clear  = 2'b10,
		set    = 2'b11
	} comT;

	function automatic logic isPcMode(wgmT mode);
		return (mode == pcPwmFf) || (mode == pcPwmOcr);
	endfunction

	function automatic logic isFastMode(wgmT mode);
		return (mode == fastFf) || (mode == fastOcr);
	endfunction

endpackage

// ==== source/timerRegs.sv ====
`timescale 1ns/1ns
`include "timer_params.svh"

module timerRegs (
	input  logic                   cp2,
	input  logic                   ireset,
	input  logic                   cp2en,
	input  logic                   tick,
	input  logic [`RAM_ADDR_W-1:0] ramAddr,
	input  logic                   ramwe,
	input  logic                   ramre,
	input  timerPkg::byteT         dbusIn,
	input  logic                   atTop,
	input  logic                   atBottom,
	input  timerPkg::byteT         tcnt,
	output timerPkg::wgmT          wgm,
	output timerPkg::comT          comA,
	output timerPkg::comT          comB,
	output logic [2:0]             csn,
	output logic                   focA,
	output logic                   focB,
	output timerPkg::byteT         ocrA,
	output timerPkg::byteT         ocrB,
	output logic [2:0]             timsk,
	output logic                   tcntWr,
	output timerPkg::byteT         tcntWrData,
	output timerPkg::byteT         dbusOut,
	output logic                   outEn
);

	timerPkg::byteT tccrA;
	timerPkg::byteT tccrB;
	timerPkg::byteT ocrABuf;
	timerPkg::byteT ocrBBuf;
	logic           wrEn;
	logic           ocrUpdate;
	logic           pwmMode;

	assign wrEn = ramwe && cp2en;

	assign wgm  = timerPkg::wgmT'({tccrB[3], tccrA[1:0]});
	assign comA = timerPkg::comT'(tccrA[7:6]);
	assign comB = timerPkg::comT'(tccrA[5:4]);
	assign csn  = tccrB[2:0];

	assign tcntWr     = wrEn && (ramAddr == `TCNT_ADDR);
	assign tcntWrData = dbusIn;

	// PWM modes reload the active compare value once per period
	assign pwmMode   = timerPkg::isPcMode(wgm) || timerPkg::isFastMode(wgm);
	assign ocrUpdate = tick && (timerPkg::isPcMode(wgm) ? atTop : atBottom);

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			tccrA <= '0;
			tccrB <= '0;
			timsk <= '0;
			focA  <= 1'b0;
			focB  <= 1'b0;
		end else begin
			focA <= 1'b0; // Strobes last one cycle
			focB <= 1'b0;
			if (wrEn && (ramAddr == `TCCRA_ADDR)) begin
				tccrA <= dbusIn & 8'hF3; // Bits 3:2 unused
			end
			if (wrEn && (ramAddr == `TCCRB_ADDR)) begin
				tccrB <= dbusIn & 8'h0F; // FOC bits not stored
				focA  <= dbusIn[7];
				focB  <= dbusIn[6];
			end
			if (wrEn && (ramAddr == `TIMSK_ADDR)) begin
				timsk <= dbusIn[2:0];
			end
		end
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			ocrABuf <= '0;
			ocrBBuf <= '0;
			ocrA    <= '0;
			ocrB    <= '0;
		end else begin
			if (wrEn && (ramAddr == `OCRA_ADDR)) begin
				ocrABuf <= dbusIn;
				if (!pwmMode) ocrA <= dbusIn; // Direct load outside PWM
			end
			if (wrEn && (ramAddr == `OCRB_ADDR)) begin
				ocrBBuf <= dbusIn;
				if (!pwmMode) ocrB <= dbusIn;
			end
			if (pwmMode && ocrUpdate) begin
				ocrA <= ocrABuf;
				ocrB <= ocrBBuf;
			end
		end
	end

	always_comb begin
		dbusOut = '0;
		outEn   = 1'b0;
		if (ramre) begin
			outEn = 1'b1;
			case (ramAddr)
				`TCCRA_ADDR: dbusOut = tccrA;
				`TCCRB_ADDR: dbusOut = tccrB;
				`TCNT_ADDR:  dbusOut = tcnt;
				`OCRA_ADDR:  dbusOut = ocrABuf; // Buffer, not active value
				`OCRB_ADDR:  dbusOut = ocrBBuf;
				`TIMSK_ADDR: dbusOut = {5'b00000, timsk};
				default:     outEn = 1'b0;
			endcase
		end
	end

	// CPU never reads and writes data space in one cycle
	rdWrExclusive: assert property (@(posedge cp2) disable iff (!ireset)
		!(ramre && ramwe));

endmodule

// ==== source/timerCounter.sv ====
`timescale 1ns/1ns

module timerCounter (
	input  logic           cp2,
	input  logic           ireset,
	input  logic           tick,
	input  timerPkg::wgmT  wgm,
	input  timerPkg::byteT ocrA,
	input  logic           tcntWr,
	input  timerPkg::byteT tcntWrData,
	output timerPkg::byteT tcnt,
	output logic           cntDown,
	output logic           atTop,
	output logic           atBottom
);

	timerPkg::byteT top;
	logic           pcMode;

	assign pcMode = timerPkg::isPcMode(wgm);

	always_comb begin
		case (wgm)
			timerPkg::ctc,
			timerPkg::pcPwmOcr,
			timerPkg::fastOcr: top = ocrA;
			default:           top = 8'hFF;
		endcase
	end

	assign atTop    = (tcnt == top);
	assign atBottom = (tcnt == 8'h00);

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			tcnt    <= '0;
			cntDown <= 1'b0;
		end else if (tcntWr) begin
			tcnt <= tcntWrData; // CPU write wins over a tick
		end else if (tick) begin
			if (pcMode) begin
				if (!cntDown) begin
					if (atTop) begin
						tcnt    <= top - 8'd1; // Turn at TOP
						cntDown <= 1'b1;
					end else begin
						tcnt <= tcnt + 8'd1;
					end
				end else begin
					if (atBottom) begin
						tcnt    <= 8'h01; // Turn at BOTTOM
						cntDown <= 1'b0;
					end else begin
						tcnt <= tcnt - 8'd1;
					end
				end
			end else begin
				cntDown <= 1'b0;
				case (wgm)
					timerPkg::ctc,
					timerPkg::fastOcr: tcnt <= atTop ? 8'h00 : tcnt + 8'd1;
					default:           tcnt <= tcnt + 8'd1; // Free-running wrap
				endcase
			end
		end
	end

	// Direction must flip back to up once BOTTOM is reached
	noDownAtBottom: assert property (@(posedge cp2) disable iff (!ireset)
		(tick && !tcntWr && pcMode && atBottom) |=> !cntDown);

endmodule

// ==== source/outputCompare.sv ====
`timescale 1ns/1ns

module outputCompare (
	input  logic           cp2,
	input  logic           ireset,
	input  logic           tick,
	input  timerPkg::wgmT  wgm,
	input  timerPkg::comT  com,
	input  logic           foc,
	input  timerPkg::byteT ocr,
	input  timerPkg::byteT tcnt,
	input  logic           cntDown,
	input  logic           cmpBlock,
	output logic           oc
);

	logic match;
	logic setOnMatch;

	assign match      = (tcnt == ocr);
	assign setOnMatch = (com == timerPkg::set);

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			oc <= 1'b0;
		end else if (com == timerPkg::off) begin
			oc <= 1'b0; // Unit disconnected
		end else if (!cmpBlock) begin
			if (timerPkg::isFastMode(wgm)) begin
				if (com == timerPkg::toggle) begin
					oc <= 1'b0; // No toggle in PWM
				end else if (tick) begin
					if (match) begin
						oc <= setOnMatch;
					end else if (tcnt == 8'h00) begin
						oc <= !setOnMatch; // Opposite level at BOTTOM
					end
				end
			end else if (timerPkg::isPcMode(wgm)) begin
				if (com == timerPkg::toggle) begin
					oc <= 1'b0;
				end else if (tick && match) begin
					// Level inverts between the up and down slope
					oc <= setOnMatch ^ cntDown;
				end
			end else begin
				if ((tick && match) || foc) begin
					case (com)
						timerPkg::toggle: oc <= !oc;
						timerPkg::clear:  oc <= 1'b0;
						timerPkg::set:    oc <= 1'b1;
						default:          oc <= 1'b0;
					endcase
				end
			end
		end
	end

endmodule

// ==== source/timerIrq.sv ====
`timescale 1ns/1ns
`include "timer_params.svh"

module timerIrq (
	input  logic                  cp2,
	input  logic                  ireset,
	input  logic                  cp2en,
	input  logic                  tick,
	input  timerPkg::wgmT         wgm,
	input  timerPkg::byteT        tcnt,
	input  logic                  cntDown,
	input  logic                  atTop,
	input  logic                  matchA,
	input  logic                  matchB,
	input  logic [2:0]            timsk,
	input  logic [`IO_ADDR_W-1:0] ioAddr,
	input  logic                  iowe,
	input  timerPkg::byteT        dbusIn,
	input  logic [`IO_ADDR_W-1:0] irqackAddr,
	input  logic                  irqack,
	output timerPkg::byteT        tifr,
	output logic                  ovfIrq,
	output logic                  cmpAIrq,
	output logic                  cmpBIrq
);

	logic [2:0] flags; // {OCFB, OCFA, TOV}
	logic [2:0] setFlag;
	logic [2:0] clrFlag;
	logic       ovfCond;
	logic       tifrWr;

	always_comb begin
		case (wgm)
			timerPkg::pcPwmFf,
			timerPkg::pcPwmOcr: ovfCond = (tcnt == 8'h00) && cntDown;
			timerPkg::normal,
			timerPkg::ctc,
			timerPkg::fastFf:   ovfCond = (tcnt == 8'hFF);
			timerPkg::fastOcr:  ovfCond = atTop;
			default:            ovfCond = 1'b0;
		endcase
	end

	assign setFlag = {3{tick}} & {matchB, matchA, ovfCond};

	assign tifrWr = cp2en && iowe && (ioAddr == `TIFR_ADDR);

	assign clrFlag[0] = (cp2en && irqack && (irqackAddr == `VEC_OVF)) || (tifrWr && dbusIn[0]);
	assign clrFlag[1] = (cp2en && irqack && (irqackAddr == `VEC_CMPA)) || (tifrWr && dbusIn[1]);
	assign clrFlag[2] = (cp2en && irqack && (irqackAddr == `VEC_CMPB)) || (tifrWr && dbusIn[2]);

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			flags <= '0;
		end else begin
			// New event beats a clear in the same cycle
			flags <= setFlag | (flags & ~clrFlag);
		end
	end

	assign tifr    = {5'b00000, flags};
	assign ovfIrq  = flags[0] && timsk[0];
	assign cmpAIrq = flags[1] && timsk[1];
	assign cmpBIrq = flags[2] && timsk[2];

	// CPU acks only an enabled pending request
	ackNeedsIrq: assert property (@(posedge cp2) disable iff (!ireset)
		irqack |-> ((irqackAddr != `VEC_OVF) || ovfIrq)
			&& ((irqackAddr != `VEC_CMPA) || cmpAIrq)
			&& ((irqackAddr != `VEC_CMPB) || cmpBIrq));

endmodule

// ==== source/timer2.sv ====
`timescale 1ns/1ns
`include "timer_params.svh"

module timer2 (
	input  logic                   cp2,
	input  logic                   ireset,
	input  logic                   cp2en,
	input  logic                   tmrCp2en,
	input  logic                   clkEn,
	input  logic [`RAM_ADDR_W-1:0] ramAddr,
	input  logic                   ramwe,
	input  logic                   ramre,
	input  logic [`IO_ADDR_W-1:0]  ioAddr,
	input  logic                   iowe,
	input  logic                   iore,
	input  timerPkg::byteT         dbusIn,
	input  logic [`IO_ADDR_W-1:0]  irqackAddr,
	input  logic                   irqack,
	output timerPkg::byteT         dbusOut,
	output logic                   outEn,
	output logic [2:0]             csn,
	output logic                   ocA,
	output logic                   ocB,
	output logic                   ocAEn,
	output logic                   ocBEn,
	output logic                   ovfIrq,
	output logic                   cmpAIrq,
	output logic                   cmpBIrq
);

	timerPkg::wgmT  wgm;
	timerPkg::comT  comA;
	timerPkg::comT  comB;
	timerPkg::byteT ocrA;
	timerPkg::byteT ocrB;
	timerPkg::byteT tcnt;
	timerPkg::byteT tcntWrData;
	timerPkg::byteT regDbus;
	timerPkg::byteT tifr;
	logic [2:0]     timsk;
	logic           tick;
	logic           focA;
	logic           focB;
	logic           tcntWr;
	logic           regOutEn;
	logic           cntDown;
	logic           atTop;
	logic           atBottom;
	logic           ioRd;

	assign tick = tmrCp2en && clkEn; // Prescaled timer step

	timerRegs uRegs (
		.cp2(cp2), .ireset(ireset), .cp2en(cp2en), .tick(tick),
		.ramAddr(ramAddr), .ramwe(ramwe), .ramre(ramre), .dbusIn(dbusIn),
		.atTop(atTop), .atBottom(atBottom), .tcnt(tcnt),
		.wgm(wgm), .comA(comA), .comB(comB), .csn(csn), .focA(focA), .focB(focB),
		.ocrA(ocrA), .ocrB(ocrB), .timsk(timsk), .tcntWr(tcntWr),
		.tcntWrData(tcntWrData), .dbusOut(regDbus), .outEn(regOutEn)
	);

	timerCounter uCounter (
		.cp2(cp2), .ireset(ireset), .tick(tick), .wgm(wgm), .ocrA(ocrA),
		.tcntWr(tcntWr), .tcntWrData(tcntWrData),
		.tcnt(tcnt), .cntDown(cntDown), .atTop(atTop), .atBottom(atBottom)
	);

	outputCompare cmpA (
		.cp2(cp2), .ireset(ireset), .tick(tick), .wgm(wgm), .com(comA), .foc(focA),
		.ocr(ocrA), .tcnt(tcnt), .cntDown(cntDown), .cmpBlock(tcntWr), .oc(ocA)
	);

	outputCompare cmpB (
		.cp2(cp2), .ireset(ireset), .tick(tick), .wgm(wgm), .com(comB), .foc(focB),
		.ocr(ocrB), .tcnt(tcnt), .cntDown(cntDown), .cmpBlock(tcntWr), .oc(ocB)
	);

	timerIrq uIrq (
		.cp2(cp2), .ireset(ireset), .cp2en(cp2en), .tick(tick), .wgm(wgm),
		.tcnt(tcnt), .cntDown(cntDown), .atTop(atTop),
		.matchA(tcnt == ocrA), .matchB(tcnt == ocrB), .timsk(timsk),
		.ioAddr(ioAddr), .iowe(iowe), .dbusIn(dbusIn),
		.irqackAddr(irqackAddr), .irqack(irqack),
		.tifr(tifr), .ovfIrq(ovfIrq), .cmpAIrq(cmpAIrq), .cmpBIrq(cmpBIrq)
	);

	// Pin drivers follow COM and waveform mode
	assign ocAEn = comA[1] || (comA[0] && (wgm[2] || !wgm[0]));
	assign ocBEn = comB[1] || (comB[0] && !wgm[2] && !wgm[0]);

	assign ioRd    = iore && (ioAddr == `TIFR_ADDR);
	assign dbusOut = ioRd ? tifr : regDbus; // I/O read first
	assign outEn   = ioRd || regOutEn;

endmodule

// ==== verif/timer2Tb.sv ====
`timescale 1ns/1ns
`include "timer_params.svh"

module timer2Tb;

	localparam int MemWords = 512;

	logic                   cp2;
	logic                   ireset;
	logic                   cp2en;
	logic                   tmrCp2en;
	logic                   clkEn;
	logic [`RAM_ADDR_W-1:0] ramAddr;
	logic                   ramwe;
	logic                   ramre;
	logic [`IO_ADDR_W-1:0]  ioAddr;
	logic                   iowe;
	logic                   iore;
	timerPkg::byteT         dbusIn;
	logic [`IO_ADDR_W-1:0]  irqackAddr;
	logic                   irqack;
	timerPkg::byteT         dbusOut;
	logic                   outEn;
	logic [2:0]             csn;
	logic                   ocA;
	logic                   ocB;
	logic                   ocAEn;
	logic                   ocBEn;
	logic                   ovfIrq;
	logic                   cmpAIrq;
	logic                   cmpBIrq;
	logic [15:0]            testMem [0:MemWords-1]; // Four words per record
	logic [2:0]             maskModel; // TIMSKn as written by the test list
	integer                 seed;
	int                     errors;
	int                     timeouts;

	timer2 u_dut (
		.cp2(cp2), .ireset(ireset), .cp2en(cp2en), .tmrCp2en(tmrCp2en), .clkEn(clkEn),
		.ramAddr(ramAddr), .ramwe(ramwe), .ramre(ramre), .ioAddr(ioAddr), .iowe(iowe),
		.iore(iore), .dbusIn(dbusIn), .irqackAddr(irqackAddr), .irqack(irqack),
		.dbusOut(dbusOut), .outEn(outEn), .csn(csn), .ocA(ocA), .ocB(ocB),
		.ocAEn(ocAEn), .ocBEn(ocBEn), .ovfIrq(ovfIrq), .cmpAIrq(cmpAIrq), .cmpBIrq(cmpBIrq)
	);

	always #20 cp2 = !cp2; // 40 ns period

	task automatic nextCycle();
		@(posedge cp2);
		#5;
	endtask

	// Drop all strobes, then idle a few cycles
	task automatic releaseBus();
		logic [31:0] rnd;
		nextCycle();
		ramwe    = 1'b0;
		ramre    = 1'b0;
		iowe     = 1'b0;
		iore     = 1'b0;
		irqack   = 1'b0;
		tmrCp2en = 1'b0;
		clkEn    = 1'b0;
		rnd = $random(seed);
		repeat (rnd[1:0]) nextCycle();
	endtask

	task automatic checkByte(input string name, input timerPkg::byteT actual,
			input timerPkg::byteT expected);
		if (actual !== expected) begin
			errors = errors + 1;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic checkPin(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			errors = errors + 1;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic checkCsn(input string name, input logic [2:0] actual,
			input logic [2:0] expected);
		if (actual !== expected) begin
			errors = errors + 1;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	function automatic logic pinValue(input logic [15:0] sel);
		case (sel[2:0])
			3'd0:    return ocA;
			3'd1:    return ocB;
			3'd2:    return ovfIrq;
			3'd3:    return cmpAIrq;
			3'd4:    return ocAEn;
			default: return ocBEn;
		endcase
	endfunction

	function automatic string pinName(input logic [15:0] sel);
		case (sel[2:0])
			3'd0:    return "ocA";
			3'd1:    return "ocB";
			3'd2:    return "ovfIrq";
			3'd3:    return "cmpAIrq";
			3'd4:    return "ocAEn";
			default: return "ocBEn";
		endcase
	endfunction

	task automatic runTicks(input logic [15:0] count);
		nextCycle();
		tmrCp2en = 1'b1;
		clkEn    = 1'b1;
		repeat (count - 16'd1) @(posedge cp2); // Last tick edge is taken in releaseBus
	endtask

	// One tick at a time until the pin reaches the level
	task automatic tickUntilPin(input logic [15:0] sel, input logic [15:0] limit,
			input logic level);
		logic [15:0] ticks;
		ticks = '0;
		@(negedge cp2);
		while ((pinValue(sel) !== level) && (ticks < limit)) begin
			nextCycle();
			tmrCp2en = 1'b1;
			clkEn    = 1'b1;
			nextCycle();
			tmrCp2en = 1'b0;
			clkEn    = 1'b0;
			@(negedge cp2);
			ticks = ticks + 16'd1;
		end
		if (pinValue(sel) !== level) begin
			timeouts = timeouts + 1;
			$display("Timeout: %s did not reach %0d within %0d ticks", pinName(sel), level, limit);
		end
	endtask

	initial begin
		int          idx;
		logic        done;
		logic [15:0] op;
		logic [15:0] addrW;
		logic [15:0] dataW;
		logic [15:0] expW;
		cp2        = 1'b0;
		ireset     = 1'b0;
		cp2en      = 1'b0;
		tmrCp2en   = 1'b0;
		clkEn      = 1'b0;
		ramAddr    = '0;
		ramwe      = 1'b0;
		ramre      = 1'b0;
		ioAddr     = '0;
		iowe       = 1'b0;
		iore       = 1'b0;
		dbusIn     = '0;
		irqackAddr = '0;
		irqack     = 1'b0;
		maskModel  = '0;
		seed       = 32'h8ca3_0da1;
		errors     = 0;
		timeouts   = 0;
		for (idx = 0; idx < MemWords; idx++) begin
			testMem[idx] = 16'hF000 | idx[15:0]; // Unknown op if unread
		end
		$readmemh("verif/timer2_tests.txt", testMem);
		repeat (5) @(posedge cp2);
		#5;
		ireset = 1'b1;
		cp2en  = 1'b1;
		@(negedge cp2);
		checkPin("outEn", outEn, 1'b0);
		checkPin("ocA", ocA, 1'b0);
		checkPin("ocB", ocB, 1'b0);
		checkPin("ovfIrq", ovfIrq, 1'b0);
		checkPin("cmpAIrq", cmpAIrq, 1'b0);
		checkPin("cmpBIrq", cmpBIrq, 1'b0);
		checkCsn("csn", csn, 3'b000);
		idx  = 0;
		done = 1'b0;
		while (!done) begin
			if (idx > MemWords - 4) begin
				errors = errors + 1;
				$display("Test list ended without an end record");
				done = 1'b1;
			end else begin
				op    = testMem[idx];
				addrW = testMem[idx + 1];
				dataW = testMem[idx + 2];
				expW  = testMem[idx + 3];
				case (op)
					16'h0000: done = 1'b1;
					16'h0001: begin
						nextCycle();
						ramAddr = addrW[`RAM_ADDR_W-1:0];
						dbusIn  = dataW[7:0];
						ramwe   = 1'b1;
						if (ramAddr == `TIMSK_ADDR) begin
							maskModel = dataW[2:0]; // Only three mask bits exist
						end
					end
					16'h0002: begin
						nextCycle();
						ramAddr = addrW[`RAM_ADDR_W-1:0];
						ramre   = 1'b1;
						@(negedge cp2);
						checkByte("dbusOut", dbusOut, expW[7:0]);
						checkPin("outEn", outEn, expW[8]);
						if (ramAddr == `TCCRB_ADDR) begin
							checkCsn("csn", csn, expW[2:0]); // CS bits of TCCRnB
						end
					end
					16'h0003: begin
						nextCycle();
						ioAddr = addrW[`IO_ADDR_W-1:0];
						dbusIn = dataW[7:0];
						iowe   = 1'b1;
					end
					16'h0004: begin
						nextCycle();
						ioAddr = addrW[`IO_ADDR_W-1:0];
						iore   = 1'b1;
						@(negedge cp2);
						checkByte("dbusOut", dbusOut, expW[7:0]);
						checkPin("outEn", outEn, expW[8]);
						if (ioAddr == `TIFR_ADDR) begin
							// Each request is its flag gated by the mask
							checkPin("ovfIrq", ovfIrq, expW[0] & maskModel[0]);
							checkPin("cmpAIrq", cmpAIrq, expW[1] & maskModel[1]);
							checkPin("cmpBIrq", cmpBIrq, expW[2] & maskModel[2]);
						end
					end
					16'h0005: begin
						nextCycle();
						irqackAddr = addrW[`IO_ADDR_W-1:0];
						irqack     = 1'b1;
					end
					16'h0006: runTicks(addrW);
					16'h0007: begin
						@(negedge cp2);
						checkPin(pinName(addrW), pinValue(addrW), expW[0]);
					end
					16'h0008: tickUntilPin(addrW, dataW, expW[0]);
					default: begin
						errors = errors + 1;
						$display("Unknown operation %0h in record %0d", op, idx / 4);
						done = 1'b1;
					end
				endcase
				if (!done) releaseBus();
				idx = idx + 4;
			end
		end
		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if ((errors == 0) && (timeouts == 0)) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== verif/timer2_tests.txt ====
// Record is op addr data expect in hex. Ops 1 write, 2 read, 3 I/O write, 4 I/O read,
// 5 ack vector, 6 run addr ticks, 7 check pin, 8 tick until pin (data is the tick limit).
// Read expect bit 8 is outEn. Pins 0 ocA, 1 ocB, 2 ovfIrq, 3 cmpAIrq, 4 ocAEn, 5 ocBEn.
// Register read-back
1 0B0 FF 000  2 0B0 00 1F3
1 0B1 FF 000  2 0B1 00 10F
1 070 FF 000  2 070 00 107
1 0B3 5A 000  2 0B3 00 15A
1 0B4 A5 000  2 0B4 00 1A5
2 0B5 00 000  1 0B0 00 000  1 0B1 00 000  1 070 00 000
// Normal mode, overflow at 0xFF
1 0B3 80 000  1 0B4 40 000  1 0B2 00 000  3 017 07 000
6 0FF 00 000  4 017 00 106  6 001 00 000  4 017 00 107
7 002 00 000  1 070 01 000  7 002 00 001
3 017 01 000  4 017 00 106  7 002 00 000
// CTC with OCRnA = 4 and toggle on A
1 070 02 000  1 0B3 04 000  1 0B0 42 000  1 0B2 00 000  3 017 07 000
7 004 00 001  6 004 00 000  2 0B2 00 104  7 000 00 000
6 001 00 000  2 0B2 00 100  7 000 00 001  7 003 00 001
6 005 00 000  7 000 00 000  8 000 08 001  2 0B2 00 100
5 007 00 000  4 017 00 100  7 003 00 000
// Fast PWM with TOP 0xFF, clear on B
1 0B4 10 000  1 0B0 23 000  1 0B2 00 000  7 005 00 001
6 001 00 000  7 001 00 001  6 00F 00 000  7 001 00 001
6 001 00 000  7 001 00 000  1 0B4 20 000  2 0B4 00 120
6 0EF 00 000  7 001 00 000  6 020 00 000  7 001 00 001
6 001 00 000  7 001 00 000  2 0B2 00 121  4 017 00 107
// Phase-correct PWM with TOP 0xFF, clear on A
1 0B0 00 000  1 0B3 40 000  1 0B0 81 000  1 0B2 00 000  3 017 07 000
6 041 00 000  7 000 00 000  6 0BE 00 000  2 0B2 00 1FF
6 001 00 000  2 0B2 00 1FE  6 0BE 00 000  7 000 00 000
6 001 00 000  7 000 00 001  6 03F 00 000  4 017 00 106
6 001 00 000  4 017 00 107  2 0B2 00 101
6 040 00 000  7 000 00 000
0 000 00 000

// ==== flist.f ====
+incdir+source
source/timerPkg.sv
source/timerRegs.sv
source/timerCounter.sv
source/outputCompare.sv
source/timerIrq.sv
source/timer2.sv
verif/timer2Tb.sv

// ==== Makefile ====
# Verilator build and run of the Timer/Counter2 testbench

all: run

compile:
	verilator --binary --timing --assert -sv -f flist.f --top-module timer2Tb -Mdir obj_dir -o simv

run: compile
	./obj_dir/simv | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
